/* common/mem_pkg.sv */
// memory stage package: widths, timing constants, operation encodings and stage structs
package mem_pkg;

	// ----------------------------------------------------------------------
	// widths and timing
	// ----------------------------------------------------------------------
	localparam int XLEN = 32;

	// cycles from the request strobe until an unanswered access fails
	localparam int MEM_TIMEOUT_CYC = 16;

	// wait counter width, one code above the limit so it can saturate
	localparam int TIMER_W = $clog2(MEM_TIMEOUT_CYC + 2);

	// ----------------------------------------------------------------------
	// encodings
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		SIZE_B = 2'd0,
		SIZE_H = 2'd1,
		SIZE_W = 2'd2
	} mem_size_e;

	typedef enum logic [1:0] {
		COP_NONE  = 2'd0,
		COP_LOAD  = 2'd1,
		COP_STORE = 2'd2
	} mem_cop_e;

	// load extension, unsigned variants zero fill
	typedef enum logic [2:0] {
		SX_LB  = 3'd0,
		SX_LH  = 3'd1,
		SX_LW  = 3'd2,
		SX_LBU = 3'd3,
		SX_LHU = 3'd4
	} sx_op_e;

	// ----------------------------------------------------------------------
	// stage payloads
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic            val;
		mem_cop_e        cop;
		mem_size_e       size;
		sx_op_e          sx_op;
		logic            we_rf;
		logic            sel_mem;
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] pc_4;
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
	} exe_to_mem_t;

	// addr is word aligned, wdata already sits in its byte lanes
	typedef struct packed {
		logic            val;
		mem_cop_e        cop;
		logic            nc;
		logic [XLEN-1:0] addr;
		logic [3:0]      be;
		logic [XLEN-1:0] wdata;
	} l1d_req_t;

	typedef struct packed {
		logic            val;
		logic            we_rf;
		logic [4:0]      rd;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] pc_4;
		logic            misalign;
		logic            bus_err;
	} mem_to_wb_t;

	// what the hazard unit sees of the instruction in this stage
	typedef struct packed {
		logic       val;
		logic       we_rf;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
	} haz_info_t;

endpackage

/* mem_stage/mem_ctrl_fsm.sv */
// access control FSM: cache request strobe, stall level, timer run and capture strobe
module mem_ctrl_fsm (
	input  logic clk,
	input  logic arst_n,
	input  logic enb,
	input  logic kill,
	input  logic val,
	input  logic is_access,
	input  logic misalign,
	input  logic l1d_ack,
	input  logic timeout,
	output logic req_val,
	output logic stall,
	output logic capture,
	output logic bus_err,
	output logic timer_run
);

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_WAIT  = 2'd1,
		ST_DRAIN = 2'd2
	} state_e;

	state_e state_q;
	state_e state_d;

	logic go;
	logic issue;
	logic done;

	// instruction may advance this cycle
	assign go = val && enb && !kill;

	// aligned access leaves for the cache
	assign issue = (state_q == ST_IDLE) && go && is_access && !misalign;

	// outstanding answer arrives, or we give up on it
	assign done = l1d_ack || timeout;

	// ----------------------------------------------------------------------
	// next state
	// ----------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (issue) begin
					state_d = ST_WAIT;
				end
			end
			ST_WAIT: begin
				// an answer in the kill cycle is consumed here, nothing left to drain
				if (done) begin
					state_d = ST_IDLE;
				end else if (kill) begin
					state_d = ST_DRAIN;
				end
			end
			ST_DRAIN: begin
				if (done) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign req_val = issue;

	// rises with the request, falls after the answer cycle
	assign stall = issue || (state_q != ST_IDLE);

	// timer counts only while an answer is owed
	assign timer_run = (state_q != ST_IDLE);

	// non-access or misaligned goes straight through, accesses on their answer
	assign capture = ((state_q == ST_IDLE) && go && (!is_access || misalign)) ||
		((state_q == ST_WAIT) && done);

	// ack wins over a timeout in the same cycle
	assign bus_err = (state_q == ST_WAIT) && timeout && !l1d_ack;

endmodule

/* mem_stage/mem_wait_timer.sv */
// wait cycle counter with one-shot timeout strobe
module mem_wait_timer (
	input  logic clk,
	input  logic arst_n,
	input  logic run,
	output logic timeout
);

	import mem_pkg::*;

	logic [TIMER_W-1:0] count_q;
	logic [TIMER_W-1:0] elapsed;

	// request cycle is cycle zero, first wait cycle is one
	assign elapsed = count_q + TIMER_W'(1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else if (!run) begin
			count_q <= '0;
		end else if (count_q != TIMER_W'(MEM_TIMEOUT_CYC)) begin
			// stops one past the limit so the strobe fires once
			count_q <= elapsed;
		end
	end

	assign timeout = run && (elapsed == TIMER_W'(MEM_TIMEOUT_CYC));

endmodule

/* mem_stage/mem_req_gen.sv */
// cache request builder: nc decision, byte enables, store lanes with bypass, misalign check
module mem_req_gen (
	input  mem_pkg::exe_to_mem_t    exe_in,
	input  logic [mem_pkg::XLEN-1:0] csr_nc_mask,
	input  logic [mem_pkg::XLEN-1:0] csr_nc_base,
	input  logic                     bp_sel,
	input  logic [mem_pkg::XLEN-1:0] bp_wb_data,
	output mem_pkg::l1d_req_t       req,
	output logic                     is_access,
	output logic                     misalign
);

	import mem_pkg::*;

	logic [1:0]      off;
	logic [3:0]      be;
	logic [XLEN-1:0] st_data;
	logic [XLEN-1:0] lanes;

	assign off = exe_in.alu_result[1:0];

	assign is_access = exe_in.val && (exe_in.cop != COP_NONE);

	// ----------------------------------------------------------------------
	// alignment
	// ----------------------------------------------------------------------
	always_comb begin
		misalign = 1'b0;
		if (is_access) begin
			case (exe_in.size)
				SIZE_H:  misalign = off[0];
				SIZE_W:  misalign = (off != 2'b00);
				default: misalign = 1'b0;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// byte enables and lanes
	// ----------------------------------------------------------------------
	always_comb begin
		case (exe_in.size)
			SIZE_B:  be = 4'b0001 << off;
			SIZE_H:  be = 4'b0011 << {off[1], 1'b0};
			default: be = 4'b1111;
		endcase
	end

	// writeback value overrides a stale register operand
	assign st_data = bp_sel ? bp_wb_data : exe_in.store_data;

	// replicate so every lane carries the data, be picks the one written
	always_comb begin
		case (exe_in.size)
			SIZE_B:  lanes = {4{st_data[7:0]}};
			SIZE_H:  lanes = {2{st_data[15:0]}};
			default: lanes = st_data;
		endcase
	end

	// ----------------------------------------------------------------------
	// request fields, strobe comes from the FSM
	// ----------------------------------------------------------------------
	always_comb begin
		req       = '0;
		req.val   = 1'b0;
		req.cop   = exe_in.cop;
		req.nc    = ((exe_in.alu_result & csr_nc_mask) == csr_nc_base);
		req.addr  = {exe_in.alu_result[XLEN-1:2], 2'b00};
		req.be    = be;
		req.wdata = lanes;
	end

endmodule

/* mem_stage/mem_wb_stage.sv */
// load alignment and extension, result select, mem to writeback register with kill
module mem_wb_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     capture,
	input  logic                     kill,
	input  logic                     bus_err,
	input  logic                     misalign,
	input  mem_pkg::exe_to_mem_t    exe_in,
	input  logic [mem_pkg::XLEN-1:0] l1d_rdata,
	output mem_pkg::mem_to_wb_t     wb_out
);

	import mem_pkg::*;

	logic [1:0]      off;
	logic [7:0]      byte_sel;
	logic [15:0]     half_sel;
	logic [XLEN-1:0] load_val;
	logic            flagged;
	mem_to_wb_t      wb_d;
	mem_to_wb_t      wb_q;

	assign off = exe_in.alu_result[1:0];

	// ----------------------------------------------------------------------
	// load data alignment
	// ----------------------------------------------------------------------
	assign byte_sel = l1d_rdata[{off, 3'b000} +: 8];
	assign half_sel = l1d_rdata[{off[1], 4'b0000} +: 16];

	always_comb begin
		case (exe_in.sx_op)
			SX_LB:   load_val = {{(XLEN-8){byte_sel[7]}}, byte_sel};
			SX_LBU:  load_val = {{(XLEN-8){1'b0}}, byte_sel};
			SX_LH:   load_val = {{(XLEN-16){half_sel[15]}}, half_sel};
			SX_LHU:  load_val = {{(XLEN-16){1'b0}}, half_sel};
			default: load_val = l1d_rdata;
		endcase
	end

	// ----------------------------------------------------------------------
	// next payload
	// ----------------------------------------------------------------------
	// failed accesses must not touch the register file
	assign flagged = bus_err || misalign;

	always_comb begin
		wb_d          = '0;
		wb_d.val      = exe_in.val;
		wb_d.we_rf    = exe_in.we_rf && !flagged;
		wb_d.rd       = exe_in.rd;
		wb_d.pc_4     = exe_in.pc_4;
		wb_d.misalign = misalign;
		wb_d.bus_err  = bus_err;
		if (flagged) begin
			wb_d.result = '0;
		end else if (exe_in.sel_mem) begin
			wb_d.result = load_val;
		end else begin
			wb_d.result = exe_in.alu_result;
		end
	end

	// ----------------------------------------------------------------------
	// stage register, kill beats capture
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_q <= '0;
		end else if (kill) begin
			wb_q <= '0;
		end else if (capture) begin
			wb_q <= wb_d;
		end
	end

	assign wb_out = wb_q;

endmodule

/* design/mem_stage_top.sv */
// memory stage top: control FSM, wait timer, request builder, writeback register, bypass wires
module mem_stage_top (
	input  logic                     clk,
	input  logic                     arst_n,
	input  mem_pkg::exe_to_mem_t    exe_in,
	input  logic                     enb,
	input  logic                     kill,
	input  logic [mem_pkg::XLEN-1:0] csr_nc_mask,
	input  logic [mem_pkg::XLEN-1:0] csr_nc_base,
	input  logic                     bp_sel,
	input  logic [mem_pkg::XLEN-1:0] bp_wb_data,
	input  logic                     l1d_ack,
	input  logic [mem_pkg::XLEN-1:0] l1d_rdata,
	output mem_pkg::l1d_req_t       l1d_req,
	output logic                     stall,
	output mem_pkg::mem_to_wb_t     wb_out,
	output logic [mem_pkg::XLEN-1:0] exe_bp_data,
	output mem_pkg::haz_info_t      haz
);

	import mem_pkg::*;

	l1d_req_t req_fields;
	logic     req_val;
	logic     is_access;
	logic     misalign;
	logic     capture;
	logic     bus_err;
	logic     timer_run;
	logic     timeout;

	mem_req_gen mem_req_gen_i (
		.exe_in      (exe_in),
		.csr_nc_mask (csr_nc_mask),
		.csr_nc_base (csr_nc_base),
		.bp_sel      (bp_sel),
		.bp_wb_data  (bp_wb_data),
		.req         (req_fields),
		.is_access   (is_access),
		.misalign    (misalign)
	);

	mem_ctrl_fsm mem_ctrl_fsm_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.enb       (enb),
		.kill      (kill),
		.val       (exe_in.val),
		.is_access (is_access),
		.misalign  (misalign),
		.l1d_ack   (l1d_ack),
		.timeout   (timeout),
		.req_val   (req_val),
		.stall     (stall),
		.capture   (capture),
		.bus_err   (bus_err),
		.timer_run (timer_run)
	);

	mem_wait_timer mem_wait_timer_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.run     (timer_run),
		.timeout (timeout)
	);

	mem_wb_stage mem_wb_stage_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.capture   (capture),
		.kill      (kill),
		.bus_err   (bus_err),
		.misalign  (misalign),
		.exe_in    (exe_in),
		.l1d_rdata (l1d_rdata),
		.wb_out    (wb_out)
	);

	// request fields with the FSM strobe merged in
	always_comb begin
		l1d_req     = req_fields;
		l1d_req.val = req_val;
	end

	// forwarding and hazard views of the instruction in this stage
	assign exe_bp_data = exe_in.alu_result;
	assign haz = '{val: exe_in.val, we_rf: exe_in.we_rf, rd: exe_in.rd,
		rs1: exe_in.rs1, rs2: exe_in.rs2};

endmodule

/* dv/l1d_model.sv */
// behavioral L1 data cache: word array, programmable answer delay, never-answer mode
module l1d_model (
	input  logic                     clk,
	input  logic                     arst_n,
	input  mem_pkg::l1d_req_t       req,
	input  logic [2:0]               delay,
	input  logic                     no_answer,
	output logic                     ack,
	output logic [mem_pkg::XLEN-1:0] rdata
);

	import mem_pkg::*;

	logic [XLEN-1:0] mem [0:63];
	logic [2:0]      cnt;
	logic [5:0]      idx_q;
	logic [5:0]      idx;

	// fill depends on every address bit
	initial begin
		for (int i = 0; i < 64; i++) begin
			mem[i] = 32'ha500_0000 ^ (i * 32'h0101_0101) ^ (i << 20);
		end
	end

	assign idx = req.addr[7:2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack   <= 1'b0;
			rdata <= '0;
			cnt   <= '0;
			idx_q <= '0;
		end else begin
			ack <= 1'b0;
			if (cnt != 3'd0) begin
				cnt <= cnt - 3'd1;
				if (cnt == 3'd1) begin
					ack   <= 1'b1;
					rdata <= mem[idx_q];
				end
			end
			if (req.val) begin
				// stores land at request time
				if (req.cop == COP_STORE) begin
					for (int b = 0; b < 4; b++) begin
						if (req.be[b]) begin
							mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
						end
					end
				end
				idx_q <= idx;
				// answer comes delay cycles after the request cycle
				if (!no_answer) begin
					if (delay <= 3'd1) begin
						ack   <= 1'b1;
						rdata <= mem[idx];
					end else begin
						cnt <= delay - 3'd1;
					end
				end
			end
		end
	end

endmodule

/* dv/tb_mem_stage.sv */
// testbench for the memory stage: clock, reset, stimulus, reference memory, checks, watchdog
module tb_mem_stage;

	import mem_pkg::*;

	localparam int N_TESTS = 6;
	localparam int ACC_PER_TEST = 16;
	localparam int CYCLE_LIMIT = N_TESTS * ACC_PER_TEST * (MEM_TIMEOUT_CYC + 4) + 100;

	logic            clk;
	logic            arst_n;
	exe_to_mem_t     exe_in;
	logic            enb;
	logic            kill;
	logic [XLEN-1:0] csr_nc_mask;
	logic [XLEN-1:0] csr_nc_base;
	logic            bp_sel;
	logic [XLEN-1:0] bp_wb_data;
	logic            l1d_ack;
	logic [XLEN-1:0] l1d_rdata;
	l1d_req_t        l1d_req;
	logic            stall;
	mem_to_wb_t      wb_out;
	logic [XLEN-1:0] exe_bp_data;
	haz_info_t       haz;
	logic [2:0]      ans_delay;
	logic            no_answer;

	logic [XLEN-1:0] ref_mem [0:63];
	integer          seed = 32'h1312_3ad6;
	int              errors;
	int              checks;
	int              test_err0;
	int              cycles;
	string           cur_test;
	logic [XLEN-1:0] next_pc;
	l1d_req_t        last_req;
	logic            last_stall;

	mem_stage_top mem_stage_top_i (
		.clk(clk), .arst_n(arst_n), .exe_in(exe_in), .enb(enb), .kill(kill),
		.csr_nc_mask(csr_nc_mask), .csr_nc_base(csr_nc_base), .bp_sel(bp_sel),
		.bp_wb_data(bp_wb_data), .l1d_ack(l1d_ack), .l1d_rdata(l1d_rdata),
		.l1d_req(l1d_req), .stall(stall), .wb_out(wb_out),
		.exe_bp_data(exe_bp_data), .haz(haz)
	);

	l1d_model l1d_model_i (
		.clk(clk), .arst_n(arst_n), .req(l1d_req), .delay(ans_delay),
		.no_answer(no_answer), .ack(l1d_ack), .rdata(l1d_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// protocol properties
	// ----------------------------------------------------------------------
	req_has_stall: assert property (@(posedge clk) disable iff (!arst_n) l1d_req.val |-> stall)
		else begin
			errors++;
			$display("request strobe seen while stall was low");
		end
	req_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		l1d_req.val |=> !l1d_req.val)
		else begin
			errors++;
			$display("request strobe held longer than one cycle");
		end
	flag_no_write: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_out.bus_err || wb_out.misalign) |-> !wb_out.we_rf)
		else begin
			errors++;
			$display("flagged access still writes the register file");
		end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act)
			else begin
				errors++;
				$display("Fail %s %s expected %h actual %h", cur_test, what, exp, act);
			end
	endtask

	function automatic exe_to_mem_t build_instr(input mem_cop_e cop, input sx_op_e sx,
		input logic [31:0] addr, input logic [31:0] sdata);
		exe_to_mem_t ins;
		ins = '0;
		ins.val = 1'b1;
		ins.cop = cop;
		ins.sx_op = sx;
		ins.size = (sx == SX_LB || sx == SX_LBU) ? SIZE_B :
			(sx == SX_LH || sx == SX_LHU) ? SIZE_H : SIZE_W;
		ins.we_rf = (cop != COP_STORE);
		ins.sel_mem = (cop == COP_LOAD);
		ins.alu_result = addr;
		ins.store_data = sdata;
		ins.rd = 5'd7;
		return ins;
	endfunction

	function automatic logic [31:0] expect_load(input logic [31:0] w, input logic [1:0] off,
		input sx_op_e sx);
		logic [31:0] sh;
		sh = w >> (8 * off);
		case (sx)
			SX_LB:   return {{24{sh[7]}}, sh[7:0]};
			SX_LBU:  return {24'h0, sh[7:0]};
			SX_LH:   return {{16{sh[15]}}, sh[15:0]};
			SX_LHU:  return {16'h0, sh[15:0]};
			default: return w;
		endcase
	endfunction

	task automatic apply_store(input logic [31:0] addr, input mem_size_e size,
		input logic [31:0] data);
		case (size)
			SIZE_B:  ref_mem[addr[7:2]][8*addr[1:0] +: 8] = data[7:0];
			SIZE_H:  ref_mem[addr[7:2]][16*addr[1] +: 16] = data[15:0];
			default: ref_mem[addr[7:2]] = data;
		endcase
	endtask

	// present at a falling edge, wait for wb_out to carry this pc
	task automatic issue_and_wait(input exe_to_mem_t ins, input logic wait_stall,
		output mem_to_wb_t res, output int lat);
		int k;
		ins.pc_4 = next_pc;
		next_pc = next_pc + 4;
		ins.rd = 5'($random(seed));
		ins.rs1 = 5'($random(seed));
		ins.rs2 = 5'($random(seed));
		ans_delay = 3'(1 + ($unsigned($random(seed)) % 4));
		exe_in = ins;
		#1;
		last_req = l1d_req;
		last_stall = stall;
		check_val("bypass data", ins.alu_result, exe_bp_data);
		check_val("hazard view", {ins.val, ins.we_rf, ins.rd, ins.rs1, ins.rs2},
			{haz.val, haz.we_rf, haz.rd, haz.rs1, haz.rs2});
		k = 0;
		forever begin
			@(negedge clk);
			k++;
			if (wb_out.val && wb_out.pc_4 == ins.pc_4) begin
				break;
			end
			if (k > 2 * MEM_TIMEOUT_CYC) begin
				errors++;
				$display("instruction at pc %h never reached writeback", ins.pc_4);
				break;
			end
			if (wait_stall) begin
				check_val("stall while waiting", 1, stall);
			end
		end
		res = wb_out;
		lat = k;
		check_val("writeback rd", ins.rd, res.rd);
		exe_in = '0;
	endtask

	task automatic end_test(input int num);
		$display("test %0d %s: %0d errors", num, cur_test, errors - test_err0);
		test_err0 = errors;
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial begin
		mem_to_wb_t  res;
		exe_to_mem_t ins;
		int          lat;
		logic [31:0] addr;
		logic [31:0] data;
		sx_op_e      sx;
		mem_size_e   sz;

		exe_in = '0;
		enb = 1'b1;
		kill = 1'b0;
		csr_nc_mask = '0;
		csr_nc_base = 32'hffff_ffff;
		bp_sel = 1'b0;
		bp_wb_data = '0;
		ans_delay = 3'd1;
		no_answer = 1'b0;
		errors = 0;
		checks = 0;
		test_err0 = 0;
		cycles = 0;
		next_pc = 32'h1000;
		for (int i = 0; i < 64; i++) begin
			ref_mem[i] = 32'ha500_0000 ^ (i * 32'h0101_0101) ^ (i << 20);
		end
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);

		cur_test = "load_store";
		for (int i = 0; i < 3; i++) begin
			addr = 32'(i + 4) << 2;
			data = $random(seed);
			issue_and_wait(build_instr(COP_STORE, SX_LW, addr, data), 1'b1, res, lat);
			apply_store(addr, SIZE_W, data);
			for (int s = 0; s < 5; s++) begin
				sx = sx_op_e'(s);
				addr[1:0] = (sx == SX_LB || sx == SX_LBU) ? 2'($random(seed)) :
					(sx == SX_LH || sx == SX_LHU) ? {1'($random(seed)), 1'b0} : 2'b00;
				issue_and_wait(build_instr(COP_LOAD, sx, addr, 0), 1'b1, res, lat);
				check_val("load result", expect_load(ref_mem[addr[7:2]], addr[1:0], sx),
					res.result);
				check_val("load we_rf", 1, res.we_rf);
				check_val("load latency", ans_delay + 1, lat);
			end
			ins = build_instr(COP_NONE, SX_LW, $random(seed), 0);
			issue_and_wait(ins, 1'b0, res, lat);
			check_val("alu result", ins.alu_result, res.result);
			check_val("non-memory stall", 0, last_stall);
			check_val("non-memory latency", 1, lat);
		end
		end_test(1);

		cur_test = "nc_and_lanes";
		for (int i = 0; i < 8; i++) begin
			sz = mem_size_e'($unsigned($random(seed)) % 3);
			addr = $random(seed);
			addr[1:0] = (sz == SIZE_B) ? addr[1:0] : (sz == SIZE_H) ? {addr[1], 1'b0} : 2'b00;
			data = $random(seed);
			csr_nc_mask = $random(seed);
			csr_nc_base = (i % 2 == 0) ? (addr & csr_nc_mask) : $random(seed);
			sx = (sz == SIZE_B) ? SX_LB : (sz == SIZE_H) ? SX_LH : SX_LW;
			issue_and_wait(build_instr(COP_STORE, sx, addr, data), 1'b1, res, lat);
			apply_store(addr, sz, data);
			check_val("nc flag", (addr & csr_nc_mask) == csr_nc_base, last_req.nc);
			check_val("word address", {addr[31:2], 2'b00}, last_req.addr);
			check_val("byte enables", (sz == SIZE_B) ? 4'b0001 << addr[1:0] :
				(sz == SIZE_H) ? 4'b0011 << (2 * addr[1]) : 4'b1111, last_req.be);
			check_val("lane data", (sz == SIZE_B) ? data[7:0] : (sz == SIZE_H) ? data[15:0] :
				data, (last_req.wdata >> (8 * addr[1:0])) &
				((sz == SIZE_B) ? 32'hff : (sz == SIZE_H) ? 32'hffff : 32'hffff_ffff));
			issue_and_wait(build_instr(COP_LOAD, SX_LW, {addr[31:2], 2'b00}, 0), 1'b1, res, lat);
			check_val("word after store", ref_mem[addr[7:2]], res.result);
		end
		end_test(2);

		cur_test = "store_bypass";
		addr = 32'h0000_0040;
		bp_sel = 1'b1;
		bp_wb_data = $random(seed);
		issue_and_wait(build_instr(COP_STORE, SX_LW, addr, ~bp_wb_data), 1'b1, res, lat);
		apply_store(addr, SIZE_W, bp_wb_data);
		bp_sel = 1'b0;
		issue_and_wait(build_instr(COP_LOAD, SX_LW, addr, 0), 1'b1, res, lat);
		check_val("bypassed word", bp_wb_data, res.result);
		end_test(3);

		cur_test = "misalign";
		for (int i = 0; i < 4; i++) begin
			addr = (i < 2) ? 32'h0000_0021 + 2 * i : 32'h0000_0031 + 2 * i;
			ins = build_instr((i % 2 == 0) ? COP_LOAD : COP_STORE, (i < 2) ? SX_LH : SX_LW, addr,
				32'h1234_5678);
			ins.we_rf = 1'b1;
			issue_and_wait(ins, 1'b0, res, lat);
			check_val("request strobe", 0, last_req.val);
			check_val("stall", 0, last_stall);
			check_val("latency", 1, lat);
			check_val("misalign flag", 1, res.misalign);
			check_val("we_rf", 0, res.we_rf);
		end
		end_test(4);

		cur_test = "timeout";
		no_answer = 1'b1;
		issue_and_wait(build_instr(COP_LOAD, SX_LW, 32'h0000_0050, 0), 1'b1, res, lat);
		check_val("timeout latency", MEM_TIMEOUT_CYC + 1, lat);
		check_val("bus_err", 1, res.bus_err);
		check_val("result on error", 0, res.result);
		no_answer = 1'b0;
		issue_and_wait(build_instr(COP_LOAD, SX_LW, 32'h0000_0050, 0), 1'b1, res, lat);
		check_val("load after timeout", ref_mem[20], res.result);
		check_val("bus_err after timeout", 0, res.bus_err);
		end_test(5);

		cur_test = "kill_and_enb";
		exe_in = build_instr(COP_LOAD, SX_LW, 32'h0000_0060, 0);
		exe_in.pc_4 = next_pc;
		next_pc = next_pc + 4;
		ans_delay = 3'd4;
		@(negedge clk);
		// load stays presented, enb low keeps it from being issued again
		kill = 1'b1;
		enb = 1'b0;
		@(negedge clk);
		kill = 1'b0;
		#1;
		check_val("wb valid after kill", 0, wb_out.val);
		for (int k = 2; k <= 4; k++) begin
			check_val("stall in drain", 1, stall);
			@(negedge clk);
			#1;
		end
		check_val("stall after late ack", 0, stall);
		check_val("late ack not captured", 0, wb_out.val);
		@(negedge clk);
		enb = 1'b1;
		issue_and_wait(build_instr(COP_NONE, SX_LW, 32'h0bad_cafe, 0), 1'b0, res, lat);
		enb = 1'b0;
		exe_in = build_instr(COP_LOAD, SX_LW, 32'h0000_0064, 0);
		repeat (3) begin
			#1;
			check_val("request with enb low", 0, l1d_req.val);
			check_val("wb holds valid", res.val, wb_out.val);
			check_val("wb holds pc", res.pc_4, wb_out.pc_4);
			check_val("wb holds result", res.result, wb_out.result);
			@(negedge clk);
		end
		exe_in = '0;
		enb = 1'b1;
		end_test(6);

		@(negedge clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* mem_stage_top.f */
common/mem_pkg.sv
mem_stage/mem_ctrl_fsm.sv
mem_stage/mem_wait_timer.sv
mem_stage/mem_req_gen.sv
mem_stage/mem_wb_stage.sv
design/mem_stage_top.sv
dv/l1d_model.sv
dv/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage_top

sources:
  - files:
      - common/mem_pkg.sv
      - mem_stage/mem_ctrl_fsm.sv
      - mem_stage/mem_wait_timer.sv
      - mem_stage/mem_req_gen.sv
      - mem_stage/mem_wb_stage.sv
      - design/mem_stage_top.sv
  - target: test
    files:
      - dv/l1d_model.sv
      - dv/tb_mem_stage.sv
